//--- verilog/muldiv_types_pkg.sv
// fixed 32-bit datapath; count_width has to stay log2 of data_width or the iteration count breaks
`default_nettype none

package muldiv_types_pkg;

    // operand, HI and LO width
    localparam int data_width = 32;

    // one engine iteration per operand bit
    localparam int count_width = $clog2(data_width);

    // operand or one HI/LO word
    typedef logic [data_width-1:0] word_t;

    // iteration index inside a multiply or divide
    typedef logic [count_width-1:0] count_t;

endpackage

`default_nettype wire

//--- verilog/muldiv_op_pkg.sv
// encodings are local to this unit and not the MIPS funct field; the decoder maps them in front
`default_nettype none

package muldiv_op_pkg;

    localparam int op_width = 4;

    typedef enum logic [op_width-1:0] {
        // no operation, a start with this code is dropped
        op_none  = 4'd0,
        // {hi, lo} = a * b
        op_mult  = 4'd1,
        op_multu = 4'd2,
        // lo = a / b, hi = a % b
        op_div   = 4'd3,
        op_divu  = 4'd4,
        // {hi, lo} += a * b
        op_madd  = 4'd5,
        op_maddu = 4'd6,
        // {hi, lo} -= a * b
        op_msub  = 4'd7,
        op_msubu = 4'd8,
        // direct moves, value taken from a
        op_mthi  = 4'd9,
        op_mtlo  = 4'd10
    } muldiv_op_t;

endpackage

`default_nettype wire

//--- verilog/muldiv_issue.sv
// start is taken only while busy is low; a_q, b_q and the controls stay fixed until write_hi_lo or clear
`timescale 1ns/1ps
`default_nettype none

module muldiv_issue (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      clear,
    input  logic                      start,
    input  muldiv_op_pkg::muldiv_op_t op,
    input  muldiv_types_pkg::word_t   a,
    input  muldiv_types_pkg::word_t   b,
    input  logic                      write_hi_lo,
    input  logic                      waiting_result,
    output logic                      mul,
    output logic                      div,
    output logic                      using_sign,
    output logic                      add,
    output logic                      sub,
    output logic                      move_hi,
    output logic                      move_lo,
    output logic                      busy,
    output muldiv_types_pkg::word_t   a_q,
    output muldiv_types_pkg::word_t   b_q
);
    import muldiv_op_pkg::*;

    logic accept;
    logic dec_mul;
    logic dec_div;
    logic dec_sign;
    logic dec_add;
    logic dec_sub;

    // op decode into engine controls
    assign dec_mul  = op inside {op_mult, op_multu, op_madd, op_maddu, op_msub, op_msubu};
    assign dec_div  = op inside {op_div, op_divu};
    assign dec_sign = op inside {op_mult, op_div, op_madd, op_msub};
    assign dec_add  = op inside {op_madd, op_maddu};
    assign dec_sub  = op inside {op_msub, op_msubu};

    // pending operation, a move in flight, or the engine still running
    assign busy   = mul | div | move_hi | move_lo | waiting_result;
    assign accept = start & ~busy;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {mul, div, using_sign, add, sub, move_hi, move_lo} <= '0;
        end else if (clear || write_hi_lo) begin
            // operation finished or aborted
            {mul, div, using_sign, add, sub, move_hi, move_lo} <= '0;
        end else if (accept) begin
            {mul, div, using_sign, add, sub} <= {dec_mul, dec_div, dec_sign, dec_add, dec_sub};
            move_hi <= (op == op_mthi);
            move_lo <= (op == op_mtlo);
        end else begin
            // moves are single cycle pulses
            move_hi <= 1'b0;
            move_lo <= 1'b0;
        end
    end

    // operands, also the move value on a_q
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= a;
            b_q <= b;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(move_hi && move_lo))
        else $error("muldiv_issue: move_hi and move_lo high together");

endmodule

`default_nettype wire

//--- verilog/div_mul.sv
// one adder, one bit per cycle; inputs must hold until write_hi_lo, division by zero leaves HI/LO undefined
`timescale 1ns/1ps
`default_nettype none

module div_mul (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clear,
    input  logic                    mul,
    input  logic                    div,
    input  logic                    using_sign,
    input  logic                    add,
    input  logic                    sub,
    input  muldiv_types_pkg::word_t a,
    input  muldiv_types_pkg::word_t b,
    input  muldiv_types_pkg::word_t hi_in,
    input  muldiv_types_pkg::word_t lo_in,
    output muldiv_types_pkg::word_t hi_out,
    output muldiv_types_pkg::word_t lo_out,
    output logic                    write_hi_lo,
    output logic                    waiting_result
);
    import muldiv_types_pkg::*;

    typedef enum logic [3:0] {
        st_wait, st_abs_a, st_abs_b, st_mul, st_div,
        st_neg_prod_lo, st_neg_prod_hi, st_neg_quot, st_neg_rem,
        st_acc_lo, st_acc_hi, st_storage
    } state_t;

    typedef enum logic [2:0] {
        srca_zero, srca_thi, srca_thi_shift, srca_hi, srca_lo
    } srca_t;

    typedef enum logic [2:0] {
        srcb_thi, srcb_tlo, srcb_a, srcb_b, srcb_abs_b, srcb_iter_b
    } srcb_t;

    typedef enum logic [1:0] {cin_zero, cin_one, cin_carry} cin_t;
    typedef enum logic [2:0] {thi_hold, thi_alu, thi_mul, thi_div, thi_zero} thi_src_t;
    typedef enum logic [1:0] {tlo_hold, tlo_alu, tlo_mul, tlo_div} tlo_src_t;
    typedef enum logic [1:0] {tick_hold, tick_inc, tick_clear} tick_op_t;

    state_t   state;
    state_t   next_state;
    state_t   after_mul;
    srca_t    srca_sel;
    srcb_t    srcb_sel;
    cin_t     cin_sel;
    thi_src_t thi_sel;
    tlo_src_t tlo_sel;
    tick_op_t tick_op;

    // temporary hi/lo, partial product or partial remainder/quotient
    word_t  thi;
    word_t  tlo;
    word_t  a_neg;
    word_t  b_neg;
    word_t  a_abs;
    word_t  b_abs;
    word_t  src_a;
    word_t  src_b;
    word_t  alu_out;
    count_t tick_count;
    logic   a_sign;
    logic   b_sign;
    logic   a_iter;
    logic   neg_b;
    logic   cin;
    logic   cout;
    logic   cout_reg;
    logic   a_neg_we;
    logic   b_neg_we;

    assign a_sign = using_sign & a[data_width-1];
    assign b_sign = using_sign & b[data_width-1];
    assign a_abs  = a_sign ? a_neg : a;
    assign b_abs  = b_sign ? b_neg : b;

    // multiply walks a from the lsb, divide from the msb (~tick is msb - tick)
    assign a_iter = mul ? a_abs[tick_count] : a_abs[~tick_count];

    // single adder
    assign {cout, alu_out} = {1'b0, src_a} + {1'b0, src_b} + {{data_width{1'b0}}, cin};

    always_comb begin
        case (srca_sel)
            srca_thi:       src_a = thi;
            srca_thi_shift: src_a = {thi[data_width-2:0], a_iter};
            srca_hi:        src_a = hi_in;
            srca_lo:        src_a = lo_in;
            default:        src_a = '0;
        endcase

        case (srcb_sel)
            srcb_tlo:    src_b = tlo;
            srcb_a:      src_b = a;
            srcb_b:      src_b = b;
            srcb_abs_b:  src_b = b_abs;
            srcb_iter_b: src_b = b_abs & {data_width{a_iter}};
            default:     src_b = thi;
        endcase
        if (neg_b) begin
            src_b = ~src_b;
        end

        case (cin_sel)
            cin_one:   cin = 1'b1;
            cin_carry: cin = cout_reg;
            default:   cin = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= st_wait;
            tick_count <= '0;
        end else begin
            state <= clear ? st_wait : next_state;
            case (tick_op)
                tick_inc:   tick_count <= tick_count + 1'b1;
                tick_clear: tick_count <= '0;
                default:    tick_count <= tick_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // carry between the low and high word steps
        cout_reg <= cout;
        if (a_neg_we) begin
            a_neg <= alu_out;
        end
        if (b_neg_we) begin
            b_neg <= alu_out;
        end

        case (thi_sel)
            thi_alu:  thi <= alu_out;
            thi_mul:  thi <= {cout, alu_out[data_width-1:1]};
            // restore when the subtract borrowed
            thi_div:  thi <= cout ? alu_out : src_a;
            thi_zero: thi <= '0;
            default:  thi <= thi;
        endcase

        case (tlo_sel)
            tlo_alu: tlo <= alu_out;
            tlo_mul: tlo <= {alu_out[0], tlo[data_width-1:1]};
            tlo_div: tlo <= {tlo[data_width-2:0], cout};
            default: tlo <= tlo;
        endcase
    end

    // accumulate only applies to products, unsigned ones included
    assign after_mul = (add || sub) ? st_acc_lo : st_storage;

    always_comb begin
        next_state = state;
        case (state)
            st_wait: begin
                if (a_sign) begin
                    next_state = st_abs_a;
                end else if (b_sign) begin
                    next_state = st_abs_b;
                end else if (mul) begin
                    next_state = st_mul;
                end else if (div) begin
                    next_state = st_div;
                end
            end
            st_abs_a:       next_state = b_sign ? st_abs_b : (mul ? st_mul : st_div);
            st_abs_b:       next_state = mul ? st_mul : st_div;
            st_mul: begin
                if (&tick_count) begin
                    next_state = (a_sign ^ b_sign) ? st_neg_prod_lo : after_mul;
                end
            end
            st_div: begin
                if (&tick_count) begin
                    if (a_sign ^ b_sign) begin
                        next_state = st_neg_quot;
                    end else if (a_sign) begin
                        next_state = st_neg_rem;
                    end else begin
                        next_state = st_storage;
                    end
                end
            end
            st_neg_prod_lo: next_state = st_neg_prod_hi;
            st_neg_prod_hi: next_state = after_mul;
            // remainder follows the dividend sign
            st_neg_quot:    next_state = a_sign ? st_neg_rem : st_storage;
            st_neg_rem:     next_state = st_storage;
            st_acc_lo:      next_state = st_acc_hi;
            st_acc_hi:      next_state = st_storage;
            default:        next_state = st_wait;
        endcase
    end

    always_comb begin
        srca_sel = srca_zero;
        srcb_sel = srcb_thi;
        cin_sel  = cin_zero;
        neg_b    = 1'b0;
        thi_sel  = thi_hold;
        tlo_sel  = tlo_hold;
        tick_op  = tick_hold;
        a_neg_we = 1'b0;
        b_neg_we = 1'b0;
        case (state)
            st_wait: begin
                // may go straight to st_mul or st_div
                tick_op = tick_clear;
                thi_sel = thi_zero;
            end
            st_abs_a, st_abs_b: begin
                // 0 - a or 0 - b
                srcb_sel = (state == st_abs_a) ? srcb_a : srcb_b;
                neg_b    = 1'b1;
                cin_sel  = cin_one;
                a_neg_we = (state == st_abs_a);
                b_neg_we = (state == st_abs_b);
                tick_op  = tick_clear;
                thi_sel  = thi_zero;
            end
            st_mul: begin
                srca_sel = srca_thi;
                srcb_sel = srcb_iter_b;
                thi_sel  = thi_mul;
                tlo_sel  = tlo_mul;
                tick_op  = tick_inc;
            end
            st_div: begin
                srca_sel = srca_thi_shift;
                srcb_sel = srcb_abs_b;
                neg_b    = 1'b1;
                cin_sel  = cin_one;
                thi_sel  = thi_div;
                tlo_sel  = tlo_div;
                tick_op  = tick_inc;
            end
            st_neg_prod_lo, st_neg_quot: begin
                srcb_sel = srcb_tlo;
                neg_b    = 1'b1;
                cin_sel  = cin_one;
                tlo_sel  = tlo_alu;
            end
            st_neg_prod_hi, st_neg_rem: begin
                neg_b   = 1'b1;
                cin_sel = (state == st_neg_rem) ? cin_one : cin_carry;
                thi_sel = thi_alu;
            end
            st_acc_lo: begin
                // lo +/- tlo, carry kept for the high word
                srca_sel = srca_lo;
                srcb_sel = srcb_tlo;
                neg_b    = sub;
                cin_sel  = sub ? cin_one : cin_zero;
                tlo_sel  = tlo_alu;
            end
            st_acc_hi: begin
                srca_sel = srca_hi;
                neg_b    = sub;
                cin_sel  = cin_carry;
                thi_sel  = thi_alu;
            end
            default: begin
            end
        endcase
    end

    assign hi_out         = thi;
    assign lo_out         = tlo;
    assign write_hi_lo    = (state == st_storage);
    assign waiting_result = (state == st_wait) ? (mul | div) : (state != st_storage);

    assert property (@(posedge clk) disable iff (reset) !(mul && div))
        else $error("div_mul: mul and div requested together");

    assert property (@(posedge clk) disable iff (reset) write_hi_lo |=> !write_hi_lo)
        else $error("div_mul: write_hi_lo longer than one cycle");

endmodule

`default_nettype wire

//--- verilog/hi_lo_regs.sv
// engine write and moves never overlap since the issue stage runs one operation at a time
`timescale 1ns/1ps
`default_nettype none

module hi_lo_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    write_hi_lo,
    input  muldiv_types_pkg::word_t hi_in_new,
    input  muldiv_types_pkg::word_t lo_in_new,
    input  logic                    move_hi,
    input  logic                    move_lo,
    input  muldiv_types_pkg::word_t move_data,
    output muldiv_types_pkg::word_t hi,
    output muldiv_types_pkg::word_t lo
);
    import muldiv_types_pkg::*;

    word_t hi_next;
    word_t lo_next;

    // engine result updates both words, a move only one
    always_comb begin
        hi_next = hi;
        lo_next = lo;
        if (write_hi_lo) begin
            hi_next = hi_in_new;
            lo_next = lo_in_new;
        end else begin
            if (move_hi) begin
                hi_next = move_data;
            end
            if (move_lo) begin
                lo_next = move_data;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else begin
            hi <= hi_next;
            lo <= lo_next;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(write_hi_lo && (move_hi || move_lo)))
        else $error("hi_lo_regs: move collides with an engine write");

endmodule

`default_nettype wire

//--- verilog/muldiv_unit.sv
// start while busy is dropped; hi/lo show a result from the cycle after done, clear aborts without a write
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      clear,
    input  logic                      start,
    input  muldiv_op_pkg::muldiv_op_t op,
    input  muldiv_types_pkg::word_t   a,
    input  muldiv_types_pkg::word_t   b,
    output logic                      busy,
    output logic                      done,
    output muldiv_types_pkg::word_t   hi,
    output muldiv_types_pkg::word_t   lo
);
    import muldiv_types_pkg::*;

    logic  mul;
    logic  div;
    logic  using_sign;
    logic  add;
    logic  sub;
    logic  move_hi;
    logic  move_lo;
    logic  waiting_result;
    word_t a_q;
    word_t b_q;
    word_t hi_out;
    word_t lo_out;

    // done is the engine's write_hi_lo pulse
    muldiv_issue issue_i (
        .clk            (clk),
        .reset          (reset),
        .clear          (clear),
        .start          (start),
        .op             (op),
        .a              (a),
        .b              (b),
        .write_hi_lo    (done),
        .waiting_result (waiting_result),
        .mul            (mul),
        .div            (div),
        .using_sign     (using_sign),
        .add            (add),
        .sub            (sub),
        .move_hi        (move_hi),
        .move_lo        (move_lo),
        .busy           (busy),
        .a_q            (a_q),
        .b_q            (b_q)
    );

    div_mul engine_i (
        .clk            (clk),
        .reset          (reset),
        .clear          (clear),
        .mul            (mul),
        .div            (div),
        .using_sign     (using_sign),
        .add            (add),
        .sub            (sub),
        .a              (a_q),
        .b              (b_q),
        .hi_in          (hi),
        .lo_in          (lo),
        .hi_out         (hi_out),
        .lo_out         (lo_out),
        .write_hi_lo    (done),
        .waiting_result (waiting_result)
    );

    hi_lo_regs hi_lo_i (
        .clk         (clk),
        .reset       (reset),
        .write_hi_lo (done),
        .hi_in_new   (hi_out),
        .lo_in_new   (lo_out),
        .move_hi     (move_hi),
        .move_lo     (move_lo),
        .move_data   (a_q),
        .hi          (hi),
        .lo          (lo)
    );

endmodule

`default_nettype wire

//--- verif/muldiv_model.svh
// updates exp_hi/exp_lo of the including module; division by zero is left unmodelled, so callers avoid it
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// 64-bit product of two words, signed or unsigned
function automatic logic [63:0] full_product(input word_t x, input word_t y, input bit is_signed);
    longint      sx;
    longint      sy;
    logic [63:0] ux;
    logic [63:0] uy;
    sx = $signed(x);
    sy = $signed(y);
    ux = x;
    uy = y;
    if (is_signed) begin
        return sx * sy;
    end
    return ux * uy;
endfunction

// expected HI/LO after one operation
task automatic model_apply(input muldiv_op_t o, input word_t x, input word_t y);
    logic [63:0] acc;
    longint      sx;
    longint      sy;
    acc = {exp_hi, exp_lo};
    sx  = $signed(x);
    sy  = $signed(y);
    case (o)
        op_mult:  {exp_hi, exp_lo} = full_product(x, y, 1'b1);
        op_multu: {exp_hi, exp_lo} = full_product(x, y, 1'b0);
        op_div: begin
            // quotient truncates toward zero, remainder takes the dividend sign
            exp_lo = word_t'(sx / sy);
            exp_hi = word_t'(sx % sy);
        end
        op_divu: begin
            exp_lo = x / y;
            exp_hi = x % y;
        end
        op_madd:  {exp_hi, exp_lo} = acc + full_product(x, y, 1'b1);
        op_maddu: {exp_hi, exp_lo} = acc + full_product(x, y, 1'b0);
        op_msub:  {exp_hi, exp_lo} = acc - full_product(x, y, 1'b1);
        op_msubu: {exp_hi, exp_lo} = acc - full_product(x, y, 1'b0);
        op_mthi:  exp_hi = x;
        op_mtlo:  exp_lo = x;
        default: begin
        end
    endcase
endtask

`endif

//--- verif/muldiv_tb.sv
// inputs change on the falling edge and outputs are sampled there; divisors are never zero
`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;
    import muldiv_types_pkg::*;
    import muldiv_op_pkg::*;

    // rough operation count over all tests, fixed waits counted as operations
    localparam int num_ops     = 120;
    localparam int cycle_limit = num_ops * 45 + 100;

    logic       clk;
    logic       reset;
    logic       clear;
    logic       start;
    muldiv_op_t op;
    word_t      a;
    word_t      b;
    logic       busy;
    logic       done;
    word_t      hi;
    word_t      lo;

    word_t  exp_hi;
    word_t  exp_lo;
    integer seed;
    int     error_count;
    int     pass_count;
    int     fail_count;
    int     done_count;
    int     cycle_count;

    `include "muldiv_model.svh"

    muldiv_unit dut_i (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .start (start),
        .op    (op),
        .a     (a),
        .b     (b),
        .busy  (busy),
        .done  (done),
        .hi    (hi),
        .lo    (lo)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // done pulses seen at the falling edge
    always @(negedge clk) begin
        if (done === 1'b1) begin
            done_count <= done_count + 1;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check_value(input string name, input word_t expected, input word_t got);
        if (got !== expected) begin
            $display("Error %s: expected %h got %h", name, expected, got);
            error_count = error_count + 1;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count = pass_count + 1;
            $display("%s: passed", name);
        end else begin
            fail_count = fail_count + 1;
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // mostly random, with corner values mixed in
    function automatic word_t rand_operand();
        word_t r;
        r = $random(seed);
        case (r[3:0])
            4'd0:    return 32'h8000_0000;
            4'd1:    return 32'hffff_ffff;
            4'd2:    return 32'h0000_0000;
            4'd3:    return 32'h0000_0001;
            default: return $random(seed);
        endcase
    endfunction

    // called at a falling edge after start has dropped
    task automatic wait_done();
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic pulse_start(input muldiv_op_t o, input word_t x, input word_t y);
        @(negedge clk);
        start = 1'b1;
        op    = o;
        a     = x;
        b     = y;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic run_op(input muldiv_op_t o, input word_t x, input word_t y);
        int  done_before;
        bit  is_move;
        done_before = done_count;
        is_move     = (o == op_mthi) || (o == op_mtlo);
        pulse_start(o, x, y);
        if (is_move) begin
            @(negedge clk);
        end else begin
            wait_done();
        end
        model_apply(o, x, y);
        check_value("hi", exp_hi, hi);
        check_value("lo", exp_lo, lo);
        check_value("busy", '0, busy);
        check_value("done pulses", is_move ? 0 : 1, done_count - done_before);
    endtask

    initial begin
        int         errors_before;
        int         done_before;
        word_t      x;
        word_t      y;
        word_t      r;
        muldiv_op_t acc_ops [4];

        acc_ops     = '{op_madd, op_maddu, op_msub, op_msubu};
        seed        = 59356;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        done_count  = 0;
        exp_hi      = '0;
        exp_lo      = '0;
        reset       = 1'b1;
        clear       = 1'b0;
        start       = 1'b0;
        op          = op_none;
        a           = '0;
        b           = '0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // test 1: reset values, then products
        errors_before = error_count;
        check_value("busy", '0, busy);
        check_value("done", '0, done);
        check_value("hi", '0, hi);
        check_value("lo", '0, lo);
        for (int i = 0; i < 40; i++) begin
            run_op(i[0] ? op_multu : op_mult, rand_operand(), rand_operand());
        end
        finish_test("test 1 reset and mult/multu", errors_before);

        // test 2: divides, sign bits forced through all four combinations
        errors_before = error_count;
        for (int i = 0; i < 40; i++) begin
            x = $random(seed);
            y = $random(seed);
            r = $random(seed);
            y = $signed(y) >>> r[4:0];
            x[31] = i[0];
            y[31] = i[1];
            if (y == '0) begin
                y = 32'h1;
            end
            run_op(i[2] ? op_divu : op_div, x, y);
        end
        finish_test("test 2 div/divu", errors_before);

        // test 3: moves, then accumulate on top of them
        errors_before = error_count;
        run_op(op_mthi, $random(seed), $random(seed));
        run_op(op_mtlo, $random(seed), $random(seed));
        for (int i = 0; i < 30; i++) begin
            r = $random(seed);
            run_op(acc_ops[r[1:0]], rand_operand(), rand_operand());
        end
        finish_test("test 3 mthi/mtlo and madd/msub", errors_before);

        // test 4: a second start while busy must be dropped
        errors_before = error_count;
        done_before   = done_count;
        x = rand_operand();
        y = rand_operand();
        pulse_start(op_mult, x, y);
        check_value("busy", 32'h1, busy);
        pulse_start(op_divu, $random(seed), 32'h7);
        wait_done();
        model_apply(op_mult, x, y);
        check_value("hi", exp_hi, hi);
        check_value("lo", exp_lo, lo);
        // an operation ends within 40 cycles, so a late second done would show here
        repeat (45) @(negedge clk);
        check_value("done pulses", 32'h1, done_count - done_before);
        check_value("busy", '0, busy);
        finish_test("test 4 start while busy", errors_before);

        // test 5: clear in the middle of a multiply
        errors_before = error_count;
        done_before   = done_count;
        pulse_start(op_mult, rand_operand(), rand_operand());
        repeat (10) @(negedge clk);
        if (busy !== 1'b1) begin
            $display("busy dropped before clear was applied");
            error_count = error_count + 1;
        end
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        repeat (40) @(negedge clk);
        check_value("done pulses", '0, done_count - done_before);
        check_value("hi", exp_hi, hi);
        check_value("lo", exp_lo, lo);
        check_value("busy", '0, busy);
        run_op(op_mult, rand_operand(), rand_operand());
        run_op(op_div, $random(seed), 32'hffff_fff3);
        finish_test("test 5 clear mid-operation", errors_before);

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verif
verilog/muldiv_types_pkg.sv
verilog/muldiv_op_pkg.sv
verilog/muldiv_issue.sv
verilog/div_mul.sv
verilog/hi_lo_regs.sv
verilog/muldiv_unit.sv
verif/muldiv_tb.sv
